/* hdl/ddr_pkg.sv */
//-----------------------------------------------------------
// Shared widths, types, command codes and reset defaults for
// the DDR command and write-data path. Referenced by scope.
//-----------------------------------------------------------

package ddr_pkg;

	//-----------------------------------------------------------
	// Field widths
	//-----------------------------------------------------------
	localparam int A_W     = 13;
	localparam int BA_W    = 2;
	localparam int CMD_W   = 3;
	localparam int CBA_W   = CMD_W + BA_W + A_W;
	localparam int DQ_W    = 16;
	localparam int DM_W    = 2;
	localparam int WBEAT_W = DM_W + DQ_W;
	localparam int DELAY_W = 4;

	// Queue geometry
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW    = 3;

	// Burst shapes
	localparam int WRITE_BEATS = 4;
	localparam int SAMPLE_LEN  = 5;

	//-----------------------------------------------------------
	// Vector types
	//-----------------------------------------------------------
	typedef logic [A_W-1:0]     addr_t;
	typedef logic [BA_W-1:0]    bank_t;
	// Command on top, then bank, then address
	typedef logic [CBA_W-1:0]   cba_t;
	typedef logic [DQ_W-1:0]    dq_t;
	typedef logic [DM_W-1:0]    dm_t;
	// Mask above data
	typedef logic [WBEAT_W-1:0] wbeat_t;
	typedef logic [DELAY_W-1:0] delay_t;

	// Codes are {ras_n, cas_n, we_n}
	typedef enum logic [CMD_W-1:0] {
		CMD_MRS   = 3'b000,
		CMD_AR    = 3'b001,
		CMD_PRE   = 3'b010,
		CMD_ACT   = 3'b011,
		CMD_WRITE = 3'b100,
		CMD_READ  = 3'b101,
		CMD_NOP   = 3'b111
	} ddr_cmd_e;

	// Idle word on the command pins
	localparam cba_t CBA_NOP = {CMD_NOP, {(BA_W + A_W){1'b0}}};

	// Post-command delays, indexed by command code
	// Code 3'b110 has no command and waits nothing
	localparam delay_t DEFAULT_DELAY [0:7] = '{
		4'd2,   // MRS
		4'd14,  // AR
		4'd2,   // PRE
		4'd4,   // ACT
		4'd8,   // WRITE
		4'd6,   // READ
		4'd0,
		4'd0    // NOP
	};

endpackage

/* hdl/ddr_fifo_if.sv */
//-----------------------------------------------------------
// Push and pop sides of one FIFO, parameterized by width.
// Writer and reader attach by modport, the FIFO by mirror.
//-----------------------------------------------------------
`timescale 1ns/1ps

interface ddr_fifo_if #(
	parameter int WIDTH = 8
);
	// Push side
	logic             push;
	logic [WIDTH-1:0] wdata;
	logic             full;

	// Pop side, rdata valid while empty is low
	logic             pop;
	logic [WIDTH-1:0] rdata;
	logic             empty;

	modport writer (
		output push, wdata,
		input  full
	);

	modport reader (
		output pop,
		input  rdata, empty
	);

	modport fifo (
		input  push, wdata, pop,
		output full, rdata, empty
	);

endinterface

/* hdl/ddr_sync_fifo.sv */
//-----------------------------------------------------------
// Eight-entry first-word-fall-through FIFO on clk.
// Holds CBA words or write beats, one instance per queue.
//-----------------------------------------------------------
`timescale 1ns/1ps

module ddr_sync_fifo #(
	parameter int WIDTH = 8
) (
	input logic        clk,
	input logic        reset,
	ddr_fifo_if.fifo   bus
);

	// Entry storage
	logic [WIDTH-1:0] mem [0:ddr_pkg::FIFO_DEPTH-1];

	logic [ddr_pkg::FIFO_AW-1:0] wr_ptr;
	logic [ddr_pkg::FIFO_AW-1:0] rd_ptr;
	// One extra bit so eight fits
	logic [ddr_pkg::FIFO_AW:0]   count;

	logic do_push;
	logic do_pop;

	// Drop push when full, ignore pop when empty
	assign do_push = bus.push & ~bus.full;
	assign do_pop  = bus.pop & ~bus.empty;

	assign bus.full  = (count == ddr_pkg::FIFO_DEPTH);
	assign bus.empty = (count == '0);
	// Head shows through without a pop
	assign bus.rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= bus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap at depth
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keep the count
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* hdl/ddr_timing_regs.sv */
//-----------------------------------------------------------
// Post-command delay table, one entry per command code.
// Written from the config port, read by the issuer.
//-----------------------------------------------------------
`timescale 1ns/1ps

module ddr_timing_regs (
	input  logic              clk,
	input  logic              reset,
	// Config write port
	input  logic              cfg_wr,
	input  ddr_pkg::ddr_cmd_e cfg_cmd,
	input  ddr_pkg::delay_t   cfg_delay,
	// Lookup from issuer
	input  ddr_pkg::ddr_cmd_e lookup_cmd,
	output ddr_pkg::delay_t   lookup_delay
);

	// Indexed by {ras_n, cas_n, we_n}
	ddr_pkg::delay_t delay_tbl [0:7];

	//-----------------------------------------------------------
	// Table update
	//-----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// Back to power-up timings
			for (int i = 0; i < 8; i++) begin
				delay_tbl[i] <= ddr_pkg::DEFAULT_DELAY[i];
			end
		end else if (cfg_wr) begin
			// Takes effect for commands accepted after this edge
			delay_tbl[cfg_cmd] <= cfg_delay;
		end
	end

	//-----------------------------------------------------------
	// Lookup
	//-----------------------------------------------------------
	// Issuer loads its counter from this same cycle
	assign lookup_delay = delay_tbl[lookup_cmd];

endmodule

/* hdl/ddr_cmd_issue.sv */
//-----------------------------------------------------------
// Takes CBA words from the queue and puts them on the DDR
// command pins for one cycle, then holds off for the delay.
//-----------------------------------------------------------
`timescale 1ns/1ps

module ddr_cmd_issue (
	input  logic              clk,
	input  logic              reset,
	// CBA queue
	ddr_fifo_if.reader        cba,
	// Delay lookup
	output ddr_pkg::ddr_cmd_e lookup_cmd,
	input  ddr_pkg::delay_t   lookup_delay,
	// DDR command pins
	output logic              ddr_ras_n,
	output logic              ddr_cas_n,
	output logic              ddr_we_n,
	output ddr_pkg::bank_t    ddr_ba,
	output ddr_pkg::addr_t    ddr_a,
	// Burst starts
	output logic              read_go,
	output logic              write_go
);

	ddr_pkg::cba_t     head;
	ddr_pkg::ddr_cmd_e head_cmd;
	ddr_pkg::cba_t     pin_word;
	ddr_pkg::delay_t   delay_cnt;
	logic              accept;

	//-----------------------------------------------------------
	// Head decode
	//-----------------------------------------------------------
	assign head     = cba.rdata;
	// Command sits in the top three bits
	assign head_cmd = ddr_pkg::ddr_cmd_e'(head[ddr_pkg::CBA_W-1 -: ddr_pkg::CMD_W]);

	assign lookup_cmd = head_cmd;

	// Take a word only when the previous delay has run out
	assign accept = ~cba.empty & (delay_cnt == '0);
	assign cba.pop = accept;

	// Strobes in the accepting cycle, bursts start at T
	assign read_go  = accept & (head_cmd == ddr_pkg::CMD_READ);
	assign write_go = accept & (head_cmd == ddr_pkg::CMD_WRITE);

	//-----------------------------------------------------------
	// Pin register and delay counter
	//-----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pin_word  <= ddr_pkg::CBA_NOP;
			delay_cnt <= '0;
		end else if (accept) begin
			// Word on the pins for exactly one cycle
			pin_word  <= head;
			delay_cnt <= lookup_delay;
		end else begin
			pin_word <= ddr_pkg::CBA_NOP;
			if (delay_cnt != '0) begin
				delay_cnt <= delay_cnt - 1'b1;
			end
		end
	end

	//-----------------------------------------------------------
	// Split onto the pins
	//-----------------------------------------------------------
	assign ddr_ras_n = pin_word[ddr_pkg::CBA_W-1];
	assign ddr_cas_n = pin_word[ddr_pkg::CBA_W-2];
	assign ddr_we_n  = pin_word[ddr_pkg::CBA_W-3];
	assign ddr_ba    = pin_word[ddr_pkg::A_W +: ddr_pkg::BA_W];
	assign ddr_a     = pin_word[ddr_pkg::A_W-1:0];

endmodule

/* hdl/ddr_burst_ctrl.sv */
//-----------------------------------------------------------
// Read sample strobe and four-beat write burst generation.
// Pops write beats and drives DQ, DM, DQS and DQS enable.
//-----------------------------------------------------------
`timescale 1ns/1ps

module ddr_burst_ctrl (
	input  logic            clk,
	input  logic            reset,
	input  logic            read_go,
	input  logic            write_go,
	// Write beat queue
	ddr_fifo_if.reader      wdata,
	// To read capture
	output logic            sample,
	// DDR data pins
	output ddr_pkg::dq_t    ddr_dq,
	output ddr_pkg::dm_t    ddr_dm,
	output logic            ddr_dqs,
	output logic            ddr_dqs_oe
);

	// Three idle cycles, then the sample window
	logic [0:7]                    read_shr;
	// Bit 0 is the enable, bit 1 the pop window
	logic [0:ddr_pkg::WRITE_BEATS] write_shr;

	ddr_pkg::wbeat_t head_beat;
	ddr_pkg::dq_t    dq_q;
	ddr_pkg::dm_t    dm_q;
	logic            beat_valid;
	logic            dqs_q;

	//-----------------------------------------------------------
	// Read shift register
	//-----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			read_shr <= '0;
		end else if (read_go) begin
			read_shr <= {3'b000, {ddr_pkg::SAMPLE_LEN{1'b1}}};
		end else begin
			read_shr <= {read_shr[1:7], 1'b0};
		end
	end

	// High T+2 through T+6
	assign sample = read_shr[1];

	//-----------------------------------------------------------
	// Write shift register
	//-----------------------------------------------------------
	// A new WRITE restarts any burst in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			write_shr <= '0;
		end else if (write_go) begin
			write_shr <= '1;
		end else begin
			write_shr <= {write_shr[1:ddr_pkg::WRITE_BEATS], 1'b0};
		end
	end

	assign ddr_dqs_oe = write_shr[0];
	// Pops at the edges ending T through T+3
	assign wdata.pop  = write_shr[1];
	assign head_beat  = wdata.rdata;

	//-----------------------------------------------------------
	// Beat register
	//-----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wdata.empty) begin
			// Underrun, send a fully masked zero beat
			dq_q <= '0;
			dm_q <= '1;
		end else begin
			dq_q <= head_beat[ddr_pkg::DQ_W-1:0];
			dm_q <= head_beat[ddr_pkg::WBEAT_W-1 -: ddr_pkg::DM_W];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			beat_valid <= 1'b0;
			dqs_q      <= 1'b0;
		end else begin
			beat_valid <= write_shr[1];
			// Odd parity of the tail marks first and third beats
			dqs_q      <= ^write_shr[2:4];
		end
	end

	// Quiet bus outside a burst
	assign ddr_dq  = beat_valid ? dq_q : '0;
	assign ddr_dm  = beat_valid ? dm_q : '0;
	assign ddr_dqs = beat_valid & dqs_q;

endmodule

/* hdl/ddr_wpath.sv */
//-----------------------------------------------------------
// DDR command and write-data path top level. Front end pushes
// CBA words and write beats, the DDR pins come out here.
//-----------------------------------------------------------
`timescale 1ns/1ps

module ddr_wpath (
	input  logic              clk,
	input  logic              reset,
	// CBA queue
	input  ddr_pkg::cba_t     cba_din,
	input  logic              cba_wr,
	output logic              cba_full,
	// Write data queue
	input  ddr_pkg::wbeat_t   wdata_din,
	input  logic              wdata_wr,
	output logic              wdata_full,
	// Timing config
	input  logic              cfg_wr,
	input  ddr_pkg::ddr_cmd_e cfg_cmd,
	input  ddr_pkg::delay_t   cfg_delay,
	// To read capture
	output logic              sample,
	// DDR pins
	output logic              ddr_ras_n,
	output logic              ddr_cas_n,
	output logic              ddr_we_n,
	output ddr_pkg::addr_t    ddr_a,
	output ddr_pkg::bank_t    ddr_ba,
	output ddr_pkg::dm_t      ddr_dm,
	output ddr_pkg::dq_t      ddr_dq,
	output logic              ddr_dqs,
	output logic              ddr_dqs_oe
);

	ddr_fifo_if #(.WIDTH($bits(ddr_pkg::cba_t)))   cba_bus ();
	ddr_fifo_if #(.WIDTH($bits(ddr_pkg::wbeat_t))) wdata_bus ();

	ddr_pkg::ddr_cmd_e lookup_cmd;
	ddr_pkg::delay_t   lookup_delay;
	logic              read_go;
	logic              write_go;

	//-----------------------------------------------------------
	// Queue write sides
	//-----------------------------------------------------------
	assign cba_bus.push    = cba_wr;
	assign cba_bus.wdata   = cba_din;
	assign cba_full        = cba_bus.full;

	assign wdata_bus.push  = wdata_wr;
	assign wdata_bus.wdata = wdata_din;
	assign wdata_full      = wdata_bus.full;

	ddr_sync_fifo #(.WIDTH($bits(ddr_pkg::cba_t))) u_cba_fifo (
		.clk   (clk),
		.reset (reset),
		.bus   (cba_bus)
	);

	ddr_sync_fifo #(.WIDTH($bits(ddr_pkg::wbeat_t))) u_wdata_fifo (
		.clk   (clk),
		.reset (reset),
		.bus   (wdata_bus)
	);

	//-----------------------------------------------------------
	// Command side
	//-----------------------------------------------------------
	ddr_timing_regs u_timing_regs (
		.clk          (clk),
		.reset        (reset),
		.cfg_wr       (cfg_wr),
		.cfg_cmd      (cfg_cmd),
		.cfg_delay    (cfg_delay),
		.lookup_cmd   (lookup_cmd),
		.lookup_delay (lookup_delay)
	);

	ddr_cmd_issue u_cmd_issue (
		.clk          (clk),
		.reset        (reset),
		.cba          (cba_bus),
		.lookup_cmd   (lookup_cmd),
		.lookup_delay (lookup_delay),
		.ddr_ras_n    (ddr_ras_n),
		.ddr_cas_n    (ddr_cas_n),
		.ddr_we_n     (ddr_we_n),
		.ddr_ba       (ddr_ba),
		.ddr_a        (ddr_a),
		.read_go      (read_go),
		.write_go     (write_go)
	);

	// Data side, started by the issuer strobes
	ddr_burst_ctrl u_burst_ctrl (
		.clk        (clk),
		.reset      (reset),
		.read_go    (read_go),
		.write_go   (write_go),
		.wdata      (wdata_bus),
		.sample     (sample),
		.ddr_dq     (ddr_dq),
		.ddr_dm     (ddr_dm),
		.ddr_dqs    (ddr_dqs),
		.ddr_dqs_oe (ddr_dqs_oe)
	);

endmodule

/* test/tb_ddr_wpath.sv */
//-----------------------------------------------------------
// Testbench for the DDR command and write-data path. Replays
// the golden record file and checks the pins cycle by cycle.
//-----------------------------------------------------------
`timescale 1ns/1ps

module tb_ddr_wpath;

	// Test names and signal tags from the record file
	typedef logic [8*16-1:0] name_t;

	logic              clk;
	logic              reset;
	ddr_pkg::cba_t     cba_din;
	logic              cba_wr;
	logic              cba_full;
	ddr_pkg::wbeat_t   wdata_din;
	logic              wdata_wr;
	logic              wdata_full;
	logic              cfg_wr;
	ddr_pkg::ddr_cmd_e cfg_cmd;
	ddr_pkg::delay_t   cfg_delay;
	logic              sample;
	logic              ddr_ras_n;
	logic              ddr_cas_n;
	logic              ddr_we_n;
	ddr_pkg::addr_t    ddr_a;
	ddr_pkg::bank_t    ddr_ba;
	ddr_pkg::dm_t      ddr_dm;
	ddr_pkg::dq_t      ddr_dq;
	logic              ddr_dqs;
	logic              ddr_dqs_oe;

	// Parsed records, one entry per line
	name_t       op_kind [$];
	name_t       op_name [$];
	int          op_a [$];
	int          op_c [$];
	logic [31:0] op_v [$];

	// Current test
	name_t       cur_name;
	int          cur_first;
	int          cur_last;
	int          cyc;
	int          test_checks;
	int          test_errors;

	// Totals
	int          tests_run;
	int          tests_failed;
	int          total_checks;
	int          total_errors;
	int          budget_sum;
	int          test_count;
	bit          load_ok;
	int unsigned seed;

	ddr_wpath u_ddr_wpath (
		.clk        (clk),
		.reset      (reset),
		.cba_din    (cba_din),
		.cba_wr     (cba_wr),
		.cba_full   (cba_full),
		.wdata_din  (wdata_din),
		.wdata_wr   (wdata_wr),
		.wdata_full (wdata_full),
		.cfg_wr     (cfg_wr),
		.cfg_cmd    (cfg_cmd),
		.cfg_delay  (cfg_delay),
		.sample     (sample),
		.ddr_ras_n  (ddr_ras_n),
		.ddr_cas_n  (ddr_cas_n),
		.ddr_we_n   (ddr_we_n),
		.ddr_a      (ddr_a),
		.ddr_ba     (ddr_ba),
		.ddr_dm     (ddr_dm),
		.ddr_dq     (ddr_dq),
		.ddr_dqs    (ddr_dqs),
		.ddr_dqs_oe (ddr_dqs_oe)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	//-----------------------------------------------------------
	// Record file loading
	//-----------------------------------------------------------
	task automatic load_records();
		int               fd;
		int               n;
		name_t            kind;
		name_t            name;
		int               a;
		int               c;
		logic [31:0]      v;
		logic [8*120-1:0] line_buf;
		load_ok    = 1'b0;
		budget_sum = 0;
		test_count = 0;
		fd = $fopen("test/ddr_wpath_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden record file");
		end else begin
			load_ok = 1'b1;
			while (!$feof(fd)) begin
				line_buf = '0;
				kind     = '0;
				name     = '0;
				a        = 0;
				c        = 1;
				v        = '0;
				n = $fgets(line_buf, fd);
				n = $sscanf(line_buf, "%s", kind);
				// Blank lines and comments
				if (n >= 1 && kind != "#") begin
					case (kind)
						"test": begin
							n = $sscanf(line_buf, "%s %s %d", kind, name, a);
							budget_sum += a;
							test_count++;
						end
						"cba": begin
							n = $sscanf(line_buf, "%s %h %d", kind, v, c);
							if (n < 3) c = 1;
						end
						"beat": n = $sscanf(line_buf, "%s %h", kind, v);
						"cfg":  n = $sscanf(line_buf, "%s %h %h", kind, a, v);
						"idle": n = $sscanf(line_buf, "%s %d", kind, a);
						"exp": begin
							n = $sscanf(line_buf, "%s %d %s %h %d", kind, a, name, v, c);
							if (n < 5) c = 1;
						end
						default: begin
							$display("Golden file has an unknown operation %0s", kind);
							load_ok = 1'b0;
						end
					endcase
					op_kind.push_back(kind);
					op_name.push_back(name);
					op_a.push_back(a);
					op_c.push_back(c);
					op_v.push_back(v);
				end
			end
			$fclose(fd);
		end
	endtask

	//-----------------------------------------------------------
	// Checking
	//-----------------------------------------------------------
	task automatic compare(input name_t sig, input logic [31:0] expv,
		input logic [31:0] actv);
		test_checks++;
		if (actv !== expv) begin
			test_errors++;
			$display("Error: test %0s, %0s in cycle %0d, expected %h, actual %h",
				cur_name, sig, cyc, expv, actv);
		end
	endtask

	// Pin groups by tag, cba is the whole command word
	task automatic read_pin(input name_t sig, output logic [31:0] val, output bit known);
		known = 1'b1;
		case (sig)
			"cba":    val = 32'({ddr_ras_n, ddr_cas_n, ddr_we_n, ddr_ba, ddr_a});
			"dq":     val = 32'(ddr_dq);
			"dm":     val = 32'(ddr_dm);
			"dqs":    val = 32'(ddr_dqs);
			"oe":     val = 32'(ddr_dqs_oe);
			"sample": val = 32'(sample);
			"cfull":  val = 32'(cba_full);
			"wfull":  val = 32'(wdata_full);
			default: begin
				val   = '0;
				known = 1'b0;
			end
		endcase
	endtask

	// Every expectation of this test that covers the cycle
	task automatic check_cycle();
		logic [31:0] actv;
		bit          known;
		for (int j = cur_first + 1; j <= cur_last; j++) begin
			if (op_kind[j] == "exp" && cyc >= op_a[j] && cyc < op_a[j] + op_c[j]) begin
				read_pin(op_name[j], actv, known);
				if (known) begin
					compare(op_name[j], op_v[j], actv);
				end else begin
					test_errors++;
					$display("Test %0s expects a signal %0s that does not exist",
						cur_name, op_name[j]);
				end
			end
		end
	endtask

	// One test cycle, sample at the falling edge, strobes drop after the rise
	task automatic step();
		@(negedge clk);
		check_cycle();
		@(posedge clk);
		#2;
		cba_wr   = 1'b0;
		wdata_wr = 1'b0;
		cfg_wr   = 1'b0;
		cyc++;
	endtask

	task automatic close_test();
		if (test_checks == 0) begin
			test_errors++;
			$display("Test %0s has no expected values", cur_name);
		end
		$display("Test %0s: %0d checks, %0d mismatches", cur_name, test_checks, test_errors);
		tests_run++;
		total_checks += test_checks;
		total_errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
	endtask

	//-----------------------------------------------------------
	// Record replay
	//-----------------------------------------------------------
	task automatic run_records();
		int         gap;
		int         k;
		logic [2:0] code;
		bit         open;
		open = 1'b0;
		for (int i = 0; i < op_kind.size(); i++) begin
			case (op_kind[i])
				"test": begin
					if (open) begin
						close_test();
					end
					open = 1'b1;
					// Idle gap, expectations are relative to the test start
					gap = $urandom % 4;
					repeat (gap) begin
						@(posedge clk);
						#2;
					end
					cur_name  = op_name[i];
					cur_first = i;
					cur_last  = i;
					while (cur_last + 1 < op_kind.size() && op_kind[cur_last + 1] != "test") begin
						cur_last++;
					end
					cyc         = 0;
					test_checks = 0;
					test_errors = 0;
				end
				"cba": begin
					// Address steps by one per repeated push
					for (k = 0; k < op_c[i]; k++) begin
						cba_din = ddr_pkg::cba_t'(op_v[i] + k);
						cba_wr  = 1'b1;
						step();
					end
				end
				"beat": begin
					wdata_din = ddr_pkg::wbeat_t'(op_v[i]);
					wdata_wr  = 1'b1;
					step();
				end
				"cfg": begin
					code      = op_a[i][2:0];
					cfg_cmd   = ddr_pkg::ddr_cmd_e'(code);
					cfg_delay = ddr_pkg::delay_t'(op_v[i]);
					cfg_wr    = 1'b1;
					step();
				end
				"idle": begin
					repeat (op_a[i]) step();
				end
				default: begin
				end
			endcase
		end
		if (open) begin
			close_test();
		end
	endtask

	task automatic watchdog(input longint limit_ns);
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic report();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
			tests_run, tests_failed, total_checks, total_errors);
		if (total_errors == 0 && tests_run > 0) begin
			$display("** PASS **");
		end else begin
			if (tests_run == 0) begin
				$display("No test records were run");
			end
			$display("** FAIL **");
		end
		$finish;
	endtask

	//-----------------------------------------------------------
	// Main sequence
	//-----------------------------------------------------------
	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		cba_din      = '0;
		cba_wr       = 1'b0;
		wdata_din    = '0;
		wdata_wr     = 1'b0;
		cfg_wr       = 1'b0;
		cfg_cmd      = ddr_pkg::CMD_NOP;
		cfg_delay    = '0;
		tests_run    = 0;
		tests_failed = 0;
		total_checks = 0;
		total_errors = 0;
		seed         = 32'hf098bf31;
		void'($urandom(seed));
		load_records();
		if (!load_ok) begin
			$display("** FAIL **");
			$finish;
		end else begin
			// Budgets plus worst gaps, reset and a margin
			fork
				watchdog(longint'(budget_sum + 4 * test_count + 103) * 20);
			join_none
			repeat (3) @(posedge clk);
			#2;
			reset = 1'b0;
			run_records();
			report();
		end
	end

endmodule

/* test/ddr_wpath_golden.txt */
# ops: test NAME BUDGET | cba HEX [N] | beat HEX | cfg CMD DELAY | idle N, one cycle each
# exp CYCLE SIGNAL HEX [COUNT]: value held from CYCLE for COUNT cycles, 0 is first driven cycle
test reset 8
idle 4
exp 0 cba 38000 4
exp 0 dq 0 4
exp 0 dm 0 4
exp 0 dqs 0 4
exp 0 oe 0 4
exp 0 sample 0 4
exp 0 cfull 0 4
exp 0 wfull 0 4
test cmd_seq 20
cba 1a123
cba 14400
cba 00032
idle 13
exp 0 cba 38000 2
exp 2 cba 1a123
exp 3 cba 38000 4
exp 7 cba 14400
exp 8 cba 38000 2
exp 10 cba 00032
exp 11 cba 38000 5
test write 20
beat 0a5a5
beat 13c3c
beat 20f0f
beat 0beef
cba 26010
idle 12
exp 5 cba 38000
exp 5 oe 0
exp 6 cba 26010
exp 6 oe 1 5
exp 11 oe 0
exp 6 dq 0
exp 7 dq a5a5
exp 8 dq 3c3c
exp 9 dq 0f0f
exp 10 dq beef
exp 11 dq 0
exp 6 dm 0
exp 7 dm 0
exp 8 dm 1
exp 9 dm 2
exp 10 dm 0
exp 11 dm 0
exp 6 dqs 0
exp 7 dqs 1
exp 8 dqs 0
exp 9 dqs 1
exp 10 dqs 0 2
exp 0 wfull 0 5
test write_empty 16
cba 20020
idle 11
exp 2 cba 20020
exp 2 oe 1 5
exp 7 oe 0
exp 3 dq 0 4
exp 3 dm 3 4
exp 7 dm 0
exp 3 dqs 1
exp 4 dqs 0
exp 5 dqs 1
exp 6 dqs 0 2
test read 16
cba 2a040
idle 11
exp 2 cba 2a040
exp 0 sample 0 4
exp 4 sample 1 5
exp 9 sample 0 3
exp 0 oe 0 12
test cfg_act 20
cfg 3 7
cba 1a123
cba 14400
idle 12
exp 3 cba 1a123
exp 4 cba 38000 7
exp 11 cba 14400
exp 12 cba 38000 3
test full 56
cba 08000
cba 00001 9
idle 37
exp 2 cba 08000
exp 0 cfull 0 9
exp 9 cfull 1 8
exp 17 cfull 0
exp 17 cba 00001
exp 20 cba 00002
exp 23 cba 00003
exp 26 cba 00004
exp 29 cba 00005
exp 32 cba 00006
exp 35 cba 00007
exp 38 cba 00008
exp 39 cba 38000 8

/* tb.f */
hdl/ddr_pkg.sv
hdl/ddr_fifo_if.sv
hdl/ddr_sync_fifo.sv
hdl/ddr_timing_regs.sv
hdl/ddr_cmd_issue.sv
hdl/ddr_burst_ctrl.sv
hdl/ddr_wpath.sv
test/tb_ddr_wpath.sv
